// File: riscvPipe_defines.svh
`ifndef RISCV_PIPE_DEFINES_SVH
`define RISCV_PIPE_DEFINES_SVH

// Architectural data path and register width
`define XLEN 64

// Every instruction word is 32 bits, no compressed forms
`define INSTR_W 32

// Integer register file size
`define REG_COUNT 32

// Index width for rs1, rs2 and rd fields
`define REG_ADDR_W 5

`endif

// File: riscvPkg.sv
package riscvPkg;

    // Major opcodes recognized by the decoder
    // Any other value in instr[6:0] is treated as a bubble
    typedef enum logic [6:0] {
        opR   = 7'b0110011, // Register-register arithmetic
        opImm = 7'b0010011  // Register-immediate arithmetic
    } opcode_e;

    // ALU operation codes, same encoding as the original ALU control
    typedef enum logic [3:0] {
        aluAnd = 4'b0000,
        aluOr  = 4'b0001,
        aluAdd = 4'b0010,
        aluSub = 4'b0110,
        aluSll = 4'b0111
    } aluOp_e;

endpackage

// File: instrDecoder.sv
`timescale 1ns/1ns
`include "riscvPipe_defines.svh"

module instrDecoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`INSTR_W-1:0]    instr,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output riscvPkg::aluOp_e       aluOperation,
    output logic                   useImm,
    output logic                   regWrite,
    output logic [`XLEN-1:0]       immediate,
    output logic [`REG_ADDR_W-1:0] destReg
);
    import riscvPkg::*;

    logic [`INSTR_W-1:0]    ifIdInstr;   // IF/ID instruction register
    logic [6:0]             opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [3:0]             functKey;    // {instr[30], funct3}
    aluOp_e                 decOp;
    logic                   decUseImm;
    logic                   decWrite;
    logic [`XLEN-1:0]       decImm;

    // Instruction word is taken every cycle, no stall path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifIdInstr <= '0; // Opcode zero decodes as a bubble
        end else begin
            ifIdInstr <= instr;
        end
    end

    assign opcode   = ifIdInstr[6:0];
    assign rd       = ifIdInstr[11:7];
    assign funct3   = ifIdInstr[14:12];
    assign rs1      = ifIdInstr[19:15];
    assign rs2      = ifIdInstr[24:20];
    assign functKey = {ifIdInstr[30], funct3};

    // Sign-extended I-type immediate
    assign decImm = {{(`XLEN-12){ifIdInstr[31]}}, ifIdInstr[31:20]};

    always_comb begin
        decOp     = aluAdd; // Harmless default for bubbles
        decUseImm = 1'b0;
        decWrite  = 1'b0;
        case (opcode)
            opR: begin
                decWrite = 1'b1;
                case (functKey)
                    4'b0000: decOp = aluAdd;
                    4'b1000: decOp = aluSub;
                    4'b0111: decOp = aluAnd;
                    4'b0110: decOp = aluOr;
                    4'b0001: decOp = aluSll;
                    default: decWrite = 1'b0; // Unsupported funct
                endcase
            end
            opImm: begin
                decUseImm = 1'b1;
                decWrite  = (funct3 == 3'b000); // Only addi is kept
            end
            default: begin
                decWrite = 1'b0;
            end
        endcase
    end

    // ID/EX control register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluOperation <= aluAdd;
            useImm       <= 1'b0;
            regWrite     <= 1'b0;
            immediate    <= '0;
            destReg      <= '0;
        end else begin
            aluOperation <= decOp;
            useImm       <= decUseImm;
            // x0 writes are dropped here so later stages never see them
            regWrite     <= decWrite && (rd != '0);
            immediate    <= decImm;
            destReg      <= rd;
        end
    end

endmodule

// File: operandUnit.sv
`timescale 1ns/1ns
`include "riscvPipe_defines.svh"

module operandUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] exMemRd,
    input  logic                   exMemRegWrite,
    input  logic [`XLEN-1:0]       exMemResult,
    input  logic                   retireValid,
    input  logic [`REG_ADDR_W-1:0] retireRd,
    input  logic [`XLEN-1:0]       retireData,
    output logic [`XLEN-1:0]       operandA,
    output logic [`XLEN-1:0]       operandB
);

    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic [`XLEN-1:0]       readData1;
    logic [`XLEN-1:0]       readData2;
    logic [`XLEN-1:0]       idExData1;   // ID/EX operand registers
    logic [`XLEN-1:0]       idExData2;
    logic [`REG_ADDR_W-1:0] idExRs1;     // Source indices for forwarding
    logic [`REG_ADDR_W-1:0] idExRs2;

    // Register file, written from the MEM/WB stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (retireValid) begin
            regs[retireRd] <= retireData;
        end
    end

    // Write-through so an instruction in ID sees the value retiring this cycle
    assign readData1 = (retireValid && (retireRd == rs1)) ? retireData : regs[rs1];
    assign readData2 = (retireValid && (retireRd == rs2)) ? retireData : regs[rs2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idExData1 <= '0;
            idExData2 <= '0;
            idExRs1   <= '0;
            idExRs2   <= '0;
        end else begin
            idExData1 <= readData1;
            idExData2 <= readData2;
            idExRs1   <= rs1;
            idExRs2   <= rs2;
        end
    end

    // Forwarding in EX, the younger EX/MEM result wins over MEM/WB
    always_comb begin
        if (exMemRegWrite && (exMemRd == idExRs1)) begin
            operandA = exMemResult;
        end else if (retireValid && (retireRd == idExRs1)) begin
            operandA = retireData;
        end else begin
            operandA = idExData1;
        end

        if (exMemRegWrite && (exMemRd == idExRs2)) begin
            operandB = exMemResult;
        end else if (retireValid && (retireRd == idExRs2)) begin
            operandB = retireData;
        end else begin
            operandB = idExData2;
        end
    end

    // x0 stays zero only because the decoder never lets an rd of zero reach WB
    noWriteToZero: assert property (
        @(posedge clk) disable iff (reset)
        retireValid |-> (retireRd != '0)
    );

endmodule

// File: executeUnit.sv
`timescale 1ns/1ns
`include "riscvPipe_defines.svh"

module executeUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       operandA,
    input  logic [`XLEN-1:0]       operandB,
    input  riscvPkg::aluOp_e       aluOperation,
    input  logic                   useImm,
    input  logic                   regWrite,
    input  logic [`XLEN-1:0]       immediate,
    input  logic [`REG_ADDR_W-1:0] destReg,
    output logic [`REG_ADDR_W-1:0] exMemRd,
    output logic                   exMemRegWrite,
    output logic [`XLEN-1:0]       exMemResult,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData
);
    import riscvPkg::*;

    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;

    assign aluB = useImm ? immediate : operandB; // addi takes the immediate

    always_comb begin
        case (aluOperation)
            aluAnd:  aluResult = operandA & aluB;
            aluOr:   aluResult = operandA | aluB;
            aluAdd:  aluResult = operandA + aluB;
            aluSub:  aluResult = operandA - aluB;
            aluSll:  aluResult = operandA << aluB[5:0]; // RV64 shift amount
            default: aluResult = '0;
        endcase
    end

    // EX/MEM then MEM/WB, no memory access in between
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMemRd       <= '0;
            exMemRegWrite <= 1'b0;
            exMemResult   <= '0;
            retireValid   <= 1'b0;
            retireRd      <= '0;
            retireData    <= '0;
        end else begin
            exMemRd       <= destReg;
            exMemRegWrite <= regWrite;
            exMemResult   <= aluResult;
            retireValid   <= exMemRegWrite;
            retireRd      <= exMemRd;
            retireData    <= exMemResult;
        end
    end

    // Decoder filtering of rd zero must survive two stage registers
    retireNotZero: assert property (
        @(posedge clk) disable iff (reset)
        retireValid |-> (retireRd != '0)
    );

    aluOpKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(aluOperation) &&
        (aluOperation inside {aluAnd, aluOr, aluAdd, aluSub, aluSll})
    );

endmodule

// File: riscvPipe.sv
`timescale 1ns/1ns
`include "riscvPipe_defines.svh"

module riscvPipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`INSTR_W-1:0]    instr,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData
);
    import riscvPkg::*;

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    aluOp_e                 aluOperation;
    logic                   useImm;
    logic                   regWrite;
    logic [`XLEN-1:0]       immediate;
    logic [`REG_ADDR_W-1:0] destReg;
    logic [`XLEN-1:0]       operandA;
    logic [`XLEN-1:0]       operandB;
    logic [`REG_ADDR_W-1:0] exMemRd;
    logic                   exMemRegWrite;
    logic [`XLEN-1:0]       exMemResult;

    instrDecoder decoder_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .rs1          (rs1),
        .rs2          (rs2),
        .aluOperation (aluOperation),
        .useImm       (useImm),
        .regWrite     (regWrite),
        .immediate    (immediate),
        .destReg      (destReg)
    );

    operandUnit operands_i (
        .clk           (clk),
        .reset         (reset),
        .rs1           (rs1),
        .rs2           (rs2),
        .exMemRd       (exMemRd),
        .exMemRegWrite (exMemRegWrite),
        .exMemResult   (exMemResult),
        .retireValid   (retireValid),
        .retireRd      (retireRd),
        .retireData    (retireData),
        .operandA      (operandA),
        .operandB      (operandB)
    );

    executeUnit execute_i (
        .clk           (clk),
        .reset         (reset),
        .operandA      (operandA),
        .operandB      (operandB),
        .aluOperation  (aluOperation),
        .useImm        (useImm),
        .regWrite      (regWrite),
        .immediate     (immediate),
        .destReg       (destReg),
        .exMemRd       (exMemRd),
        .exMemRegWrite (exMemRegWrite),
        .exMemResult   (exMemResult),
        .retireValid   (retireValid),
        .retireRd      (retireRd),
        .retireData    (retireData)
    );

endmodule

// File: riscvPipeTb.sv
`timescale 1ns/1ns
`include "riscvPipe_defines.svh"

module riscvPipeTb;
    import riscvPkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 2000;
    localparam int DRAIN_CYCLES = 5;
    localparam int PIPE_SLOTS   = 5;    // Slot pushed at edge k is checked after edge k+4
    localparam int TIMEOUT      = 2100; // Reset, 2000 instructions, drain and margin

    logic                   clk;
    logic                   reset;
    logic [`INSTR_W-1:0]    instr;
    logic                   retireValid;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0]       retireData;

    logic [31:0]            rngState;
    logic [`XLEN-1:0]       modelRegs [`REG_COUNT]; // Architectural state in program order
    logic [`INSTR_W-1:0]    progWords [$];
    logic                   slotValid [$];
    logic [`REG_ADDR_W-1:0] slotRd [$];
    logic [`XLEN-1:0]       slotData [$];
    logic                   expValid;
    logic [`REG_ADDR_W-1:0] expRd;
    logic [`XLEN-1:0]       expData;
    int                     cycleCount;

    riscvPipe dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState;
    endfunction

    function automatic int randBelow(input int n);
        return int'((nextRand() >> 16) % n); // Upper bits of the LCG are the useful ones
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, opR};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, opImm};
    endfunction

    function automatic logic [31:0] randomInstr();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] r;
        logic [31:0] word;
        kind = randBelow(10);
        rd   = 5'(randBelow(8)); // x0..x7 keeps dependencies close together
        rs1  = 5'(randBelow(8));
        rs2  = 5'(randBelow(8));
        imm  = 12'(randBelow(4096));
        case (kind)
            0, 1, 2: word = iType(imm, rs1, 3'b000, rd);             // addi
            3, 8:    word = rType(7'b0000000, rs2, rs1, 3'b000, rd); // add
            4:       word = rType(7'b0100000, rs2, rs1, 3'b000, rd); // sub
            5:       word = rType(7'b0000000, rs2, rs1, 3'b111, rd); // and
            6:       word = rType(7'b0000000, rs2, rs1, 3'b110, rd); // or
            7:       word = rType(7'b0000000, rs2, rs1, 3'b001, rd); // sll
            default: begin
                case (randBelow(3))
                    0: begin
                        r    = nextRand();
                        word = {r[31:7], 7'b0000011}; // Load opcode
                    end
                    1:       word = rType(7'b0000000, rs2, rs1, 3'b100, rd); // xor
                    default: word = iType(imm, rs1, 3'(1 + randBelow(7)), rd);
                endcase
            end
        endcase
        return word;
    endfunction

    // ISA-level execution of one instruction against modelRegs
    task automatic runModel(input logic [31:0] word, output logic writes,
                            output logic [4:0] rd, output logic [`XLEN-1:0] data);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [3:0]       key;
        logic             known;
        a     = modelRegs[word[19:15]];
        b     = modelRegs[word[24:20]];
        imm   = {{(`XLEN-12){word[31]}}, word[31:20]};
        key   = {word[30], word[14:12]};
        known = 1'b1;
        data  = '0;
        if (word[6:0] == opR) begin
            case (key)
                4'b0000: data = a + b;
                4'b1000: data = a - b;
                4'b0111: data = a & b;
                4'b0110: data = a | b;
                4'b0001: data = a << b[5:0];
                default: known = 1'b0;
            endcase
        end else if ((word[6:0] == opImm) && (word[14:12] == 3'b000)) begin
            data = a + imm;
        end else begin
            known = 1'b0;
        end
        rd     = word[11:7];
        writes = known && (rd != 5'd0);
        if (writes) begin
            modelRegs[rd] = data;
        end
    endtask

    task automatic pushSlot(input logic valid, input logic [4:0] rd, input logic [`XLEN-1:0] data);
        slotValid.push_back(valid);
        slotRd.push_back(rd);
        slotData.push_back(data);
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Retire port is sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        if (slotValid.size() == PIPE_SLOTS) begin
            expValid = slotValid.pop_front();
            expRd    = slotRd.pop_front();
            expData  = slotData.pop_front();
            checkValue("retireValid", 64'(expValid), 64'(retireValid));
            if (expValid) begin
                checkValue("retireRd", 64'(expRd), 64'(retireRd));
                checkValue("retireData", expData, retireData);
            end
        end else begin
            checkValue("retireValid", 64'd0, 64'(retireValid)); // Reset and pipeline fill
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic                   writes;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        rngState   = 32'd92362;
        cycleCount = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end

        // Directed prefix with short dependency chains
        progWords.push_back(iType(12'd5, 5'd0, 3'b000, 5'd1));
        progWords.push_back(iType(-12'sd3, 5'd1, 3'b000, 5'd2));                // Distance 1
        progWords.push_back(rType(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));       // Distances 1, 2
        progWords.push_back(rType(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4));       // Distance 3 on x1
        progWords.push_back(iType(-12'sd1, 5'd0, 3'b000, 5'd5));                // All ones
        progWords.push_back(rType(7'b0000000, 5'd3, 5'd5, 3'b111, 5'd6));
        progWords.push_back(rType(7'b0000000, 5'd4, 5'd6, 3'b110, 5'd7));
        progWords.push_back(rType(7'b0000000, 5'd2, 5'd7, 3'b001, 5'd1));
        progWords.push_back(iType(12'h800, 5'd0, 3'b000, 5'd2));                // Most negative imm
        progWords.push_back(rType(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd0));       // Write to x0
        progWords.push_back(iType(12'd7, 5'd0, 3'b000, 5'd0));
        progWords.push_back(rType(7'b0000000, 5'd2, 5'd0, 3'b000, 5'd3));       // Reads x0
        progWords.push_back(rType(7'b0100000, 5'd1, 5'd0, 3'b000, 5'd4));
        progWords.push_back(32'h0000_2283);                                     // Load, unsupported
        progWords.push_back(iType(12'hfff, 5'd4, 3'b000, 5'd5));
        progWords.push_back(rType(7'b0000000, 5'd5, 5'd4, 3'b100, 5'd6));       // xor, unsupported
        progWords.push_back(iType(12'd9, 5'd5, 3'b010, 5'd6));                  // slti, unsupported
        progWords.push_back(rType(7'b0000000, 5'd0, 5'd5, 3'b110, 5'd6));
        while (progWords.size() < NUM_INSTR) begin
            progWords.push_back(randomInstr());
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            pushSlot(1'b0, '0, '0);
        end
        reset <= 1'b0;

        foreach (progWords[i]) begin
            @(posedge clk);
            runModel(progWords[i], writes, rd, data);
            instr <= progWords[i];
            pushSlot(writes, rd, data);
        end

        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            instr <= '0;
            pushSlot(1'b0, '0, '0);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
riscvPkg.sv
instrDecoder.sv
operandUnit.sv
executeUnit.sv
riscvPipe.sv
riscvPipeTb.sv

// File: Makefile
# Verilator build and run for the pipeline testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= riscvPipeTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
